//--- tb.f
verilog/mem_pkg.sv
verilog/axil_mem_port.sv
verilog/ram_controller.sv
verilog/sram_bank.sv
verilog/mem_subsystem.sv
sim/mem_subsystem_assert.sv
sim/tb_mem_subsystem.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_mem_subsystem
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;
	import mem_pkg::*;

	localparam int max_txn = 400;
	localparam int cycles_per_txn = 20;
	localparam int cycle_limit = max_txn * cycles_per_txn;
	localparam int preload_per_bank = 32;
	localparam int random_txn = 260;
	localparam int alias_w = bank_sel_bit - bank_index_w;

	typedef struct packed {
		access_kind_e kind;
		logic [mem_data_w-1:0] data;
	} expect_t;

	logic clk;
	logic reset;
	logic [axil_addr_w-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axil_data_w-1:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axil_addr_w-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axil_data_w-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic uart_received_data;

	// Reference model of both banks
	logic [mem_data_w-1:0] model_b1 [bank_depth];
	logic [mem_data_w-1:0] model_b2 [bank_depth];
	bit written_b1 [bank_depth];
	bit written_b2 [bank_depth];

	expect_t exp_q [$];
	int issued = 0;
	int done_count = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'hf7ef5739;

	mem_subsystem dut (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.uart_received_data(uart_received_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////
	// Random bits
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	function automatic logic rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
		return b;
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++)
			v = {v[30:0], rand_bit()};
		return v;
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Status word is all ones with the UART flag in bit 1
	function automatic logic [mem_data_w-1:0] expected_read(input logic [mem_addr_w-1:0] addr,
			input logic uart);
		logic [mem_data_w-1:0] status;
		status = '1;
		status[1] = uart;
		if (addr == status_addr)
			return status;
		else if (addr[bank_sel_bit])
			return model_b1[addr[bank_index_w-1:0]];
		else
			return model_b2[addr[bank_index_w-1:0]];
	endfunction

	function automatic bit entry_written(input logic [mem_addr_w-1:0] addr);
		if (addr[bank_sel_bit])
			return written_b1[addr[bank_index_w-1:0]];
		return written_b2[addr[bank_index_w-1:0]];
	endfunction

	task automatic apply_write(input logic [mem_addr_w-1:0] addr,
			input logic [mem_data_w-1:0] data, input logic [1:0] be);
		logic [mem_data_w-1:0] word;
		logic [bank_index_w-1:0] idx;
		idx = addr[bank_index_w-1:0];
		word = addr[bank_sel_bit] ? model_b1[idx] : model_b2[idx];
		if (be[0])
			word[7:0] = data[7:0];
		if (be[1])
			word[15:8] = data[15:8];
		if (addr != status_addr) begin
			if (addr[bank_sel_bit]) begin
				model_b1[idx] = word;
				written_b1[idx] = written_b1[idx] || (be == 2'b11);
			end else begin
				model_b2[idx] = word;
				written_b2[idx] = written_b2[idx] || (be == 2'b11);
			end
		end
	endtask

	////////////////////////////////////////
	// Failure and compare tasks
	////////////////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_rdata(input string name, input logic [mem_data_w-1:0] got,
			input logic [mem_data_w-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_kind(input string name, input access_kind_e got,
			input access_kind_e exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	////////////////////////////////////////
	// Response checking
	////////////////////////////////////////

	task automatic take_read_response();
		expect_t e;
		if (exp_q.size() == 0) begin
			fail_run("an R response arrived with no access outstanding");
		end else begin
			e = exp_q.pop_front();
			check_kind("response channel", access_read, e.kind);
			check_rdata("rdata", rdata[mem_data_w-1:0], e.data);
			check_rdata("rdata upper", rdata[axil_data_w-1:mem_data_w], '0);
			check_resp("rresp", rresp, 2'b00);
			done_count++;
		end
	endtask

	task automatic take_write_response();
		expect_t e;
		if (exp_q.size() == 0) begin
			fail_run("a B response arrived with no access outstanding");
		end else begin
			e = exp_q.pop_front();
			check_kind("response channel", access_write, e.kind);
			check_resp("bresp", bresp, 2'b00);
			done_count++;
		end
	endtask

	// Handshakes seen at the rising edge
	initial begin
		forever begin
			@(posedge clk);
			if (rvalid && rready)
				take_read_response();
			if (bvalid && bready)
				take_write_response();
		end
	end

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		fail_run("timeout: the run did not finish within the cycle limit");
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Falling edge, new back-pressure each cycle
	task automatic next_cycle();
		@(negedge clk);
		rready = rand_bit();
		bready = rand_bit();
	endtask

	task automatic wait_response();
		while (done_count != issued)
			next_cycle();
	endtask

	task automatic do_read(input logic [mem_addr_w-1:0] addr);
		expect_t e;
		logic taken;
		e.kind = access_read;
		e.data = expected_read(addr, uart_received_data);
		exp_q.push_back(e);
		issued++;
		araddr = {addr, 1'b0};
		arvalid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = arready;
			next_cycle();
		end
		arvalid = 1'b0;
		wait_response();
	endtask

	task automatic do_write(input logic [mem_addr_w-1:0] addr,
			input logic [mem_data_w-1:0] data, input logic [3:0] strb);
		expect_t e;
		logic taken;
		e.kind = access_write;
		e.data = '0;
		apply_write(addr, data, strb[1:0]);
		exp_q.push_back(e);
		issued++;
		awaddr = {addr, 1'b0};
		wdata = {~data, data};
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = awready && wready;
			next_cycle();
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		wait_response();
	endtask

	// Full-word writes, random alias bits
	task automatic preload_banks();
		logic [alias_w-1:0] upper;
		logic [mem_data_w-1:0] data;
		for (int i = 0; i < preload_per_bank; i++) begin
			upper = alias_w'(take_bits(alias_w));
			data = mem_data_w'(take_bits(mem_data_w));
			do_write({1'b1, upper, bank_index_w'(i * 8)}, data, 4'hF);
			upper = alias_w'(take_bits(alias_w));
			data = mem_data_w'(take_bits(mem_data_w));
			do_write({1'b0, upper, bank_index_w'(i * 8)}, data, 4'hF);
		end
	endtask

	task automatic directed_checks();
		// Bank 1 write, bank 2 at the same index untouched
		do_write(16'h8040, 16'h1234, 4'hF);
		do_read(16'h8040);
		do_read(16'h0040);
		// Aliasing through bits 14 to 8
		do_write(16'hD540, 16'hBEEF, 4'hF);
		do_read(16'hAA40);
		do_write(16'h1380, 16'h7A61, 4'hF);
		do_read(16'h6C80);
		// Byte enables
		do_write(16'h8040, 16'h5A5A, 4'b0001);
		do_read(16'h8040);
		do_write(16'h8040, 16'hC3C3, 4'b0010);
		do_read(16'h8040);
		// Status word
		uart_received_data = 1'b0;
		do_read(status_addr);
		uart_received_data = 1'b1;
		do_read(status_addr);
		do_write(status_addr, 16'h0000, 4'hF);
		do_read(status_addr);
	endtask

	task automatic random_traffic(input int count);
		logic [mem_addr_w-1:0] addr;
		logic [mem_data_w-1:0] data;
		logic [3:0] strb;
		logic is_write;
		for (int n = 0; n < count; n++) begin
			if (take_bits(3) == 0)
				addr = status_addr;
			else
				addr = mem_addr_w'(take_bits(mem_addr_w));
			data = mem_data_w'(take_bits(mem_data_w));
			strb = 4'(take_bits(4));
			is_write = rand_bit();
			uart_received_data = rand_bit();
			// An entry is loaded before it is read
			if (addr != status_addr && !entry_written(addr)) begin
				is_write = 1'b1;
				strb = 4'hF;
			end
			if (is_write)
				do_write(addr, data, strb);
			else
				do_read(addr);
		end
	endtask

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		uart_received_data = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		next_cycle();
		preload_banks();
		directed_checks();
		random_traffic(random_txn);
		next_cycle();
		// Nothing outstanding, so neither response channel may be valid
		if (rvalid || bvalid) begin
			fail_run("a response is valid with no access outstanding");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- sim/mem_subsystem_assert.sv
`timescale 1ns/1ns

module mem_subsystem_assert (
	input logic clk,
	input logic reset,
	input logic rvalid,
	input logic rready,
	input logic bvalid,
	input logic bready,
	input logic bank1_start,
	input logic bank2_start,
	input logic req_valid,
	input logic req_ready,
	input logic rsp_valid
);

	// From the request handshake up to the reply cycle
	logic rsp_pending;

	always_ff @(posedge clk) begin
		if (reset)
			rsp_pending <= 1'b0;
		else if (rsp_valid)
			rsp_pending <= 1'b0;
		else if (req_valid && req_ready)
			rsp_pending <= 1'b1;
	end

	// R and B hold valid until the master takes the response
	r_valid_held: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	b_valid_held: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	// One bank per access
	one_bank_start: assert property (@(posedge clk) disable iff (reset)
		!(bank1_start && bank2_start))
		else $error("both bank start pulses high");

	no_accept_pending: assert property (@(posedge clk) disable iff (reset)
		rsp_pending |-> !req_ready)
		else $error("req_ready high while a response is pending");

endmodule

////////////////////////////////////////
// Attachments
////////////////////////////////////////

bind axil_mem_port mem_subsystem_assert port_assert (
	.clk(clk), .reset(reset),
	.rvalid(rvalid), .rready(rready), .bvalid(bvalid), .bready(bready),
	.bank1_start(1'b0), .bank2_start(1'b0),
	.req_valid(1'b0), .req_ready(1'b0), .rsp_valid(1'b0)
);

bind ram_controller mem_subsystem_assert ctrl_assert (
	.clk(clk), .reset(reset),
	.rvalid(1'b0), .rready(1'b0), .bvalid(1'b0), .bready(1'b0),
	.bank1_start(bank1_start), .bank2_start(bank2_start),
	.req_valid(req_valid), .req_ready(req_ready), .rsp_valid(rsp_valid)
);

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
	input logic clk,
	input logic reset,

	input logic [mem_pkg::axil_addr_w-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [mem_pkg::axil_data_w-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [mem_pkg::axil_addr_w-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [mem_pkg::axil_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	input logic uart_received_data
);
	import mem_pkg::*;

	// Port to controller
	logic req_valid;
	logic req_ready;
	mem_req_t req;
	logic rsp_valid;
	mem_rsp_t rsp;

	// Controller to banks
	logic bank1_start;
	logic bank2_start;
	bank_cmd_t bank1_cmd;
	bank_cmd_t bank2_cmd;
	bank_done_t bank1_done;
	bank_done_t bank2_done;

	axil_mem_port port (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

	ram_controller ctrl (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.uart_received_data(uart_received_data),
		.bank1_start(bank1_start), .bank2_start(bank2_start),
		.bank1_cmd(bank1_cmd), .bank2_cmd(bank2_cmd),
		.bank1_done(bank1_done), .bank2_done(bank2_done)
	);

	// Bank 1 holds addresses with bit 15 set
	sram_bank bank1 (
		.clk(clk), .reset(reset),
		.start(bank1_start), .cmd(bank1_cmd), .done(bank1_done)
	);

	sram_bank bank2 (
		.clk(clk), .reset(reset),
		.start(bank2_start), .cmd(bank2_cmd), .done(bank2_done)
	);

endmodule

//--- verilog/sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
	input logic clk,
	input logic reset,
	input logic start,
	input mem_pkg::bank_cmd_t cmd,
	output mem_pkg::bank_done_t done
);
	import mem_pkg::*;

	logic [mem_data_w-1:0] mem [bank_depth];

	bank_cmd_t pend;
	logic busy;
	logic [wait_cnt_w-1:0] wait_cnt;
	logic finish;

	logic [mem_data_w-1:0] old_word;
	logic [mem_data_w-1:0] new_word;

	logic [act_w-1:0] done_tag;
	logic [mem_data_w-1:0] done_data;

	////////////////////////////////////////
	// Wait counter
	////////////////////////////////////////

	// The start cycle is the first wait cycle
	assign finish = busy && (wait_cnt == wait_cnt_w'(1));

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			wait_cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			wait_cnt <= wait_cnt_w'(sram_wait_cycles - 1);
		end else if (busy) begin
			if (finish)
				busy <= 1'b0;
			else
				wait_cnt <= wait_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			pend <= cmd;
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Byte merge
	always_comb begin
		old_word = mem[pend.index];
		for (int b = 0; b < 2; b++)
			new_word[b*8 +: 8] = pend.be[b] ? pend.data[b*8 +: 8] : old_word[b*8 +: 8];
	end

	always_ff @(posedge clk) begin
		if (finish && pend.kind == access_write)
			mem[pend.index] <= new_word;
	end

	// Tag and data published together at completion
	always_ff @(posedge clk) begin
		if (reset)
			done_tag <= '1;
		else if (finish)
			done_tag <= pend.tag;
	end

	always_ff @(posedge clk) begin
		if (finish)
			done_data <= (pend.kind == access_write) ? new_word : old_word;
	end

	assign done = '{tag: done_tag, data: done_data};

endmodule

//--- verilog/ram_controller.sv
`timescale 1ns/1ns

module ram_controller (
	input logic clk,
	input logic reset,

	input logic req_valid,
	input mem_pkg::mem_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output mem_pkg::mem_rsp_t rsp,

	input logic uart_received_data,

	output logic bank1_start,
	output logic bank2_start,
	output mem_pkg::bank_cmd_t bank1_cmd,
	output mem_pkg::bank_cmd_t bank2_cmd,
	input mem_pkg::bank_done_t bank1_done,
	input mem_pkg::bank_done_t bank2_done
);
	import mem_pkg::*;

	ctrl_state_e state;
	logic [act_w-1:0] act_tag;

	// Held for the access in flight
	bank_cmd_t cmd_q;
	access_kind_e kind_q;
	logic bank_sel_q;
	logic [mem_data_w-1:0] rdata_q;

	logic is_status;
	logic [mem_data_w-1:0] status_word;
	logic [act_w-1:0] target_tag;
	logic [act_w-1:0] issue_tag;
	bank_done_t sel_done;
	logic bank_hit;

	// All ones is reserved for the reset value of a bank tag
	function automatic logic [act_w-1:0] next_tag(input logic [act_w-1:0] t);
		logic [act_w-1:0] n;
		n = t + 1'b1;
		if (&n)
			n = '0;
		return n;
	endfunction

	////////////////////////////////////////
	// Decode and tag compare
	////////////////////////////////////////

	always_comb begin
		is_status = (req.addr == status_addr);
		status_word = {status_fixed[mem_data_w-1:2], uart_received_data, status_fixed[0]};
		target_tag = req.addr[bank_sel_bit] ? bank1_done.tag : bank2_done.tag;
		// Skip a tag the bank still shows as done
		issue_tag = (act_tag == target_tag) ? next_tag(act_tag) : act_tag;
		sel_done = bank_sel_q ? bank1_done : bank2_done;
		bank_hit = (sel_done.tag == cmd_q.tag);
	end

	assign req_ready = (state == ctrl_idle);
	assign rsp_valid = (state == ctrl_reply);
	assign rsp = '{data: rdata_q, kind: kind_q};
	assign bank1_cmd = cmd_q;
	assign bank2_cmd = cmd_q;

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrl_idle;
			act_tag <= '0;
			bank1_start <= 1'b0;
			bank2_start <= 1'b0;
		end else begin
			bank1_start <= 1'b0;
			bank2_start <= 1'b0;
			case (state)
				ctrl_idle: begin
					if (req_valid) begin
						if (is_status) begin
							state <= ctrl_reply;
						end else begin
							state <= ctrl_wait_bank;
							bank1_start <= req.addr[bank_sel_bit];
							bank2_start <= !req.addr[bank_sel_bit];
							act_tag <= next_tag(issue_tag);
						end
					end
				end
				ctrl_wait_bank: begin
					if (bank_hit)
						state <= ctrl_reply;
				end
				default: state <= ctrl_idle;
			endcase
		end
	end

	// Access payload
	always_ff @(posedge clk) begin
		if (state == ctrl_idle && req_valid) begin
			kind_q <= req.kind;
			bank_sel_q <= req.addr[bank_sel_bit];
			cmd_q <= '{kind: req.kind, index: req.addr[bank_index_w-1:0],
				data: req.data, be: req.be, tag: issue_tag};
			if (is_status)
				rdata_q <= status_word;
		end else if (state == ctrl_wait_bank && bank_hit) begin
			rdata_q <= sel_done.data;
		end
	end

endmodule

//--- verilog/axil_mem_port.sv
`timescale 1ns/1ns

module axil_mem_port (
	input logic clk,
	input logic reset,

	// Write address and data
	input logic [mem_pkg::axil_addr_w-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [mem_pkg::axil_data_w-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,

	// Write response
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	// Read address and data
	input logic [mem_pkg::axil_addr_w-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [mem_pkg::axil_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	// Controller side
	output logic req_valid,
	output mem_pkg::mem_req_t req,
	input logic req_ready,
	input logic rsp_valid,
	input mem_pkg::mem_rsp_t rsp
);
	import mem_pkg::*;

	// High from acceptance until the R or B handshake
	logic busy;
	logic rd_accept;
	logic wr_accept;
	logic [mem_data_w-1:0] rdata_q;

	////////////////////////////////////////
	// Acceptance
	////////////////////////////////////////

	// Read wins, write needs AW and W together
	always_comb begin
		rd_accept = !busy && arvalid;
		wr_accept = !busy && !arvalid && awvalid && wvalid;
	end

	assign arready = rd_accept;
	assign awready = wr_accept;
	assign wready = wr_accept;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			req_valid <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_accept || wr_accept) begin
				busy <= 1'b1;
				req_valid <= 1'b1;
			end else if (req_valid && req_ready) begin
				req_valid <= 1'b0;
			end

			// Kind of the response picks the channel
			if (rsp_valid) begin
				if (rsp.kind == access_read)
					rvalid <= 1'b1;
				else
					bvalid <= 1'b1;
			end

			// Done only when the master takes it
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				busy <= 1'b0;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Request and read data registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			req.kind <= access_read;
			req.addr <= araddr[axil_addr_w-1:1];
			req.data <= '0;
			req.be <= 2'b11;
		end else if (wr_accept) begin
			req.kind <= access_write;
			req.addr <= awaddr[axil_addr_w-1:1];
			req.data <= wdata[mem_data_w-1:0];
			req.be <= wstrb[1:0];
		end

		if (rsp_valid && rsp.kind == access_read)
			rdata_q <= rsp.data;
	end

	// Upper read bits are always zero
	assign rdata = {{(axil_data_w - mem_data_w){1'b0}}, rdata_q};
	assign rresp = axil_resp_okay;
	assign bresp = axil_resp_okay;

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Word address and word width on the memory side
	localparam int mem_addr_w = 16;
	localparam int mem_data_w = 16;

	// AXI4-Lite side, byte addressed
	localparam int axil_data_w = 32;
	localparam int axil_addr_w = 17;

	// Bank storage, only the low index bits are kept
	localparam int bank_index_w = 8;
	localparam int bank_depth = 1 << bank_index_w;
	localparam int bank_sel_bit = 15;

	// Bank latency
	localparam int sram_wait_cycles = 2;
	localparam int wait_cnt_w = $clog2(sram_wait_cycles + 1);

	// Action tag width
	localparam int act_w = 4;

	////////////////////////////////////////
	// Fixed values
	////////////////////////////////////////

	localparam logic [mem_addr_w-1:0] status_addr = 16'hBF01;
	// Bit 1 is replaced by the UART flag
	localparam logic [mem_data_w-1:0] status_fixed = 16'hFFFD;
	localparam logic [1:0] axil_resp_okay = 2'b00;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef enum logic {
		access_read,
		access_write
	} access_kind_e;

	typedef enum logic [1:0] {
		ctrl_idle,
		ctrl_wait_bank,
		ctrl_reply
	} ctrl_state_e;

	// Port to controller
	typedef struct packed {
		access_kind_e kind;
		logic [mem_addr_w-1:0] addr;
		logic [mem_data_w-1:0] data;
		logic [1:0] be;
	} mem_req_t;

	// Controller to bank
	typedef struct packed {
		access_kind_e kind;
		logic [bank_index_w-1:0] index;
		logic [mem_data_w-1:0] data;
		logic [1:0] be;
		logic [act_w-1:0] tag;
	} bank_cmd_t;

	// Bank to controller
	typedef struct packed {
		logic [act_w-1:0] tag;
		logic [mem_data_w-1:0] data;
	} bank_done_t;

	// Controller to port
	typedef struct packed {
		logic [mem_data_w-1:0] data;
		access_kind_e kind;
	} mem_rsp_t;

endpackage
